// File: run_sim.sh
#!/bin/sh
# Build and run the eth_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module eth_core_tb -f tb.f -Mdir obj_dir -o eth_core_tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/eth_core_tb_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: source/bus_gpio.sv
`timescale 1ns/10ps

module bus_gpio #(
    parameter logic [eth_core_pkg::ABUSWIDTH-1:0] BASEADDR = eth_core_pkg::GPIO_BASEADDR_DEF,
    parameter logic [eth_core_pkg::ABUSWIDTH-1:0] HIGHADDR = eth_core_pkg::GPIO_HIGHADDR_DEF,
    parameter int                                 IO_WIDTH = 8
) (
    input  logic                   BUS_CLK,
    input  logic                   rst_n,
    input  eth_core_pkg::bus_req_t bus_req,
    input  logic [IO_WIDTH-1:0]    gpio_in,
    output logic [7:0]             bus_rdata,
    output logic [IO_WIDTH-1:0]    gpio_out
);
    import eth_core_pkg::*;

    localparam logic [ABUSWIDTH-1:0] OFF_OUT = 0;    // Output register
    localparam logic [ABUSWIDTH-1:0] OFF_IN  = 1;    // Input readback

    logic [ABUSWIDTH-1:0] offset;                    // Address relative to base
    logic                 in_win;                    // Address inside window
    logic [7:0]           rd_mux;

    assign offset = bus_req.add - BASEADDR;
    assign in_win = (bus_req.add >= BASEADDR) && (bus_req.add <= HIGHADDR);

    always_comb begin
        rd_mux = 8'h00;                              // Unmapped reads return 0
        if (in_win) begin
            case (offset)
                OFF_OUT: rd_mux = 8'(gpio_out);
                OFF_IN:  rd_mux = 8'(gpio_in);
                default: rd_mux = 8'h00;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            bus_rdata <= 8'h00;
        end else begin
            if (bus_req.wr && in_win && (offset == OFF_OUT)) begin
                gpio_out <= bus_req.wdata[IO_WIDTH-1:0];  // Only output reg is writable
            end
            if (bus_req.rd) begin
                bus_rdata <= rd_mux;                 // Valid the cycle after strobe
            end
        end
    end

    a_window: assert property (@(posedge BUS_CLK) HIGHADDR >= BASEADDR)
        else $error("bus_gpio: HIGHADDR below BASEADDR");

endmodule

// File: source/count_source.sv
`timescale 1ns/10ps

module count_source (
    input  logic        BUS_CLK,
    input  logic        rst_n,
    input  logic        start,
    input  logic        stop_req,
    input  logic        fifo_full,
    output logic        fifo_write,
    output logic [31:0] fifo_data,
    output logic        running
);
    import eth_core_pkg::*;

    src_state_e  state;
    logic        start_q;      // Start bit, registered once
    logic        start_d;      // start_q delayed for edge detect
    logic        start_rise;
    logic        stop_now;     // Close request or start bit cleared
    logic [31:0] count;        // Next word to send

    assign start_rise = start_q && !start_d;
    assign stop_now   = stop_req || !start;
    assign running    = (state == SRC_RUN);
    assign fifo_write = running && !fifo_full && !stop_now;  // Stall on full
    assign fifo_data  = count;

    always_ff @(posedge BUS_CLK) begin
        if (!rst_n) begin
            state   <= SRC_IDLE;
            start_q <= 1'b0;
            start_d <= 1'b0;
            count   <= 32'd0;
        end else begin
            start_q <= start;
            start_d <= start_q;
            if (stop_now) begin
                state <= SRC_IDLE;             // Stop wins over a start edge
                count <= 32'd0;                // Restart begins at word 0
            end else begin
                case (state)
                    SRC_IDLE: begin
                        if (start_rise) begin
                            state <= SRC_RUN;  // Locked until stopped
                        end
                    end
                    SRC_RUN: begin
                        if (fifo_write) begin
                            count <= count + 32'd1;
                        end
                    end
                    default: state <= SRC_IDLE;
                endcase
            end
        end
    end

    a_respect_full: assert property (@(posedge BUS_CLK) disable iff (!rst_n)
        fifo_write |-> !fifo_full)
        else $error("count_source: write into full FIFO");

endmodule

// File: source/eth_core.sv
`timescale 1ns/10ps

module eth_core #(
    parameter logic [eth_core_pkg::ABUSWIDTH-1:0] GPIO_BASEADDR = eth_core_pkg::GPIO_BASEADDR_DEF,
    parameter logic [eth_core_pkg::ABUSWIDTH-1:0] GPIO_HIGHADDR = eth_core_pkg::GPIO_HIGHADDR_DEF,
    parameter int                                 FIFO_DEPTH    = eth_core_pkg::FIFO_DEPTH_DEF
) (
    input  logic                    BUS_CLK,
    input  logic                    rst_n,
    input  eth_core_pkg::rbcp_req_t rbcp_req,
    input  logic                    tcp_close_req,
    input  logic                    tcp_rx_wr,
    input  logic [7:0]              tcp_rx_data,
    input  logic                    tcp_tx_full,
    output logic                    rbcp_ack,
    output logic [7:0]              rbcp_rd,
    output logic                    tcp_close_ack,
    output logic [10:0]             tcp_rx_wc,
    output logic                    tcp_tx_wr,
    output logic [7:0]              tcp_tx_data,
    output logic [7:0]              led
);
    import eth_core_pkg::*;

    bus_req_t    bus_req;
    logic [7:0]  bus_rdata;
    logic [7:0]  gpio_out;       // Bit 0 starts the stream
    logic [7:0]  gpio_in;        // Status readback
    logic        running;
    logic        fifo_write;
    logic [31:0] fifo_data;
    logic        fifo_full;
    logic        fifo_empty;
    logic        rx_data_nz;     // Received byte carries data

    rbcp_to_bus i_rbcp_to_bus (
        .BUS_CLK   (BUS_CLK),
        .rst_n     (rst_n),
        .rbcp_req  (rbcp_req),
        .bus_rdata (bus_rdata),
        .rbcp_ack  (rbcp_ack),
        .rbcp_rd   (rbcp_rd),
        .bus_req   (bus_req)
    );

    bus_gpio #(
        .BASEADDR (GPIO_BASEADDR),
        .HIGHADDR (GPIO_HIGHADDR),
        .IO_WIDTH (8)
    ) i_gpio (
        .BUS_CLK   (BUS_CLK),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .gpio_in   (gpio_in),
        .bus_rdata (bus_rdata),
        .gpio_out  (gpio_out)
    );

    count_source i_source (
        .BUS_CLK    (BUS_CLK),
        .rst_n      (rst_n),
        .start      (gpio_out[0]),
        .stop_req   (tcp_close_req),
        .fifo_full  (fifo_full),
        .fifo_write (fifo_write),
        .fifo_data  (fifo_data),
        .running    (running)
    );

    fifo_32_to_8 #(
        .DEPTH (FIFO_DEPTH)
    ) i_data_fifo (
        .BUS_CLK (BUS_CLK),
        .rst_n   (rst_n),
        .write   (fifo_write),
        .data_in (fifo_data),
        .tx_full (tcp_tx_full),
        .full    (fifo_full),
        .empty   (fifo_empty),
        .tx_wr   (tcp_tx_wr),
        .tx_data (tcp_tx_data)
    );

    assign gpio_in    = {5'b00000, fifo_empty, fifo_full, running};
    assign rx_data_nz = tcp_rx_wr && (tcp_rx_data != 8'h00);

    always_ff @(posedge BUS_CLK) begin
        if (!rst_n) begin
            tcp_rx_wc     <= 11'd0;
            tcp_close_ack <= 1'b0;
        end else begin
            tcp_close_ack <= tcp_close_req;    // Close acknowledged one cycle later
            if (tcp_rx_wr) begin
                tcp_rx_wc <= tcp_rx_wc + 11'd1;  // Length of current write burst
            end else begin
                tcp_rx_wc <= 11'd0;
            end
        end
    end

    // Active low status LEDs
    assign led = ~{tcp_close_ack, tcp_close_req, tcp_rx_wr, tcp_tx_wr,
                   fifo_full, fifo_empty, fifo_write, rx_data_nz};

endmodule

// File: source/eth_core_pkg.sv
package eth_core_pkg;

    localparam int ABUSWIDTH = 32;                           // Internal bus address width

    localparam logic [ABUSWIDTH-1:0] GPIO_BASEADDR_DEF = 32'h1000;  // GPIO window start
    localparam logic [ABUSWIDTH-1:0] GPIO_HIGHADDR_DEF = 32'h101f;  // GPIO window end

    localparam int FIFO_DEPTH_DEF = 1024;                    // Data FIFO depth in words

    // One RBCP request as presented by the network stack
    typedef struct packed {
        logic                 act;    // Request strobe
        logic [31:0]          addr;   // Register address
        logic [7:0]           wd;     // Write data
        logic                 we;     // Write request
        logic                 re;     // Read request
    } rbcp_req_t;

    // Internal byte bus, one strobe per access
    typedef struct packed {
        logic                 wr;     // Write strobe
        logic                 rd;     // Read strobe
        logic [ABUSWIDTH-1:0] add;    // Address
        logic [7:0]           wdata;  // Write data
    } bus_req_t;

    typedef enum logic [1:0] {
        BUS_NOP   = 2'd0,             // Nothing pending
        BUS_WRITE = 2'd1,
        BUS_READ  = 2'd2
    } bus_op_e;

    typedef enum logic {
        SRC_IDLE = 1'b0,              // Waiting for start edge
        SRC_RUN  = 1'b1               // Producing words
    } src_state_e;

endpackage

// File: source/fifo_32_to_8.sv
`timescale 1ns/10ps

module fifo_32_to_8 #(
    parameter int DEPTH = eth_core_pkg::FIFO_DEPTH_DEF
) (
    input  logic        BUS_CLK,
    input  logic        rst_n,
    input  logic        write,
    input  logic [31:0] data_in,
    input  logic        tx_full,
    output logic        full,
    output logic        empty,
    output logic        tx_wr,
    output logic [7:0]  tx_data
);
    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;  // Pointer width

    logic [31:0]   mem [DEPTH];     // Word storage
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   used;            // Words held, including partly sent one
    logic [1:0]    lane;            // Byte lane of the word at rd_ptr
    logic          push;
    logic          pop;             // Last byte of a word leaves
    logic [31:0]   cur_word;

    assign full     = (used == (AW+1)'(DEPTH));
    assign empty    = (used == '0);
    assign tx_wr    = !empty && !tx_full;      // Stack takes a byte when not almost full
    assign push     = write && !full;
    assign pop      = tx_wr && (lane == 2'd3);
    assign cur_word = mem[rd_ptr];
    assign tx_data  = cur_word[8*lane +: 8];   // LSB first

    always_ff @(posedge BUS_CLK) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
            lane   <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (tx_wr) begin
                lane <= lane + 2'd1;           // Wraps to 0 on word boundary
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   used <= used + 1'b1;
                2'b01:   used <= used - 1'b1;
                default: used <= used;         // Both or neither
            endcase
        end
    end

    // Producer must respect full, consumer side must never see an empty read
    a_no_overflow: assert property (@(posedge BUS_CLK) disable iff (!rst_n)
        write |-> !full)
        else $error("fifo_32_to_8: write while full");

    a_no_underflow: assert property (@(posedge BUS_CLK) disable iff (!rst_n)
        tx_wr |-> !empty)
        else $error("fifo_32_to_8: read while empty");

endmodule

// File: source/rbcp_to_bus.sv
`timescale 1ns/10ps

module rbcp_to_bus (
    input  logic                    BUS_CLK,
    input  logic                    rst_n,
    input  eth_core_pkg::rbcp_req_t rbcp_req,
    input  logic [7:0]              bus_rdata,
    output logic                    rbcp_ack,
    output logic [7:0]              rbcp_rd,
    output eth_core_pkg::bus_req_t  bus_req
);
    import eth_core_pkg::*;

    bus_op_e              op;         // Request latched at edge N
    logic [31:0]          addr_q;     // Latched RBCP address
    logic [7:0]           wd_q;       // Latched RBCP write data
    logic                 wr_q;       // Write strobe, cycle N+1
    logic                 rd_q;       // Read strobe, cycle N+1
    logic [ABUSWIDTH-1:0] add_q;      // Bus address
    logic [7:0]           wdata_q;    // Bus write data
    logic                 ack_q;      // Acknowledge after edge N+2

    always_ff @(posedge BUS_CLK) begin
        if (!rst_n) begin
            op    <= BUS_NOP;
            wr_q  <= 1'b0;
            rd_q  <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            if (rbcp_req.act && rbcp_req.we) begin
                op <= BUS_WRITE;                   // Write wins if both set
            end else if (rbcp_req.act && rbcp_req.re) begin
                op <= BUS_READ;
            end else begin
                op <= BUS_NOP;                     // Pending op lasts one cycle
            end
            wr_q  <= (op == BUS_WRITE);            // Single-cycle strobes
            rd_q  <= (op == BUS_READ);
            ack_q <= wr_q || rd_q;                 // Slave answered at this edge
        end
    end

    // Address and data follow the control path one stage behind
    always_ff @(posedge BUS_CLK) begin
        if (rbcp_req.act) begin
            addr_q <= rbcp_req.addr;
            wd_q   <= rbcp_req.wd;
        end
        if (op != BUS_NOP) begin
            add_q   <= ABUSWIDTH'(addr_q);
            wdata_q <= wd_q;
        end
    end

    assign bus_req  = '{wr: wr_q, rd: rd_q, add: add_q, wdata: wdata_q};
    assign rbcp_ack = ack_q;
    assign rbcp_rd  = ack_q ? bus_rdata : 8'h00;  // Slave data registered with ack

    a_one_strobe: assert property (@(posedge BUS_CLK) disable iff (!rst_n)
        !(bus_req.wr && bus_req.rd))
        else $error("rbcp_to_bus: write and read strobe together");

endmodule

// File: tb.f
source/eth_core_pkg.sv
source/rbcp_to_bus.sv
source/bus_gpio.sv
source/fifo_32_to_8.sv
source/count_source.sv
source/eth_core.sv
tb/eth_core_tb.sv

// File: tb/eth_core_tb.sv
`timescale 1ns/10ps

module eth_core_tb;
    import eth_core_pkg::*;

    localparam int          TB_FIFO_DEPTH = 16;             // Small FIFO, full reached fast
    localparam logic [31:0] OUT_ADDR      = GPIO_BASEADDR_DEF;
    localparam logic [31:0] IN_ADDR       = GPIO_BASEADDR_DEF + 32'd1;  // Status readback
    localparam logic [31:0] FAR_ADDR      = 32'h2000;       // Outside GPIO window
    localparam int          STREAM_WORDS  = 200;            // Words checked per run
    localparam int          FILL_LIMIT    = 8 * TB_FIFO_DEPTH;
    localparam int          RUN_LIMIT     = 16 * STREAM_WORDS;
    localparam int          DRAIN_LIMIT   = 64 * TB_FIFO_DEPTH;
    localparam int          STREAM_CYCLES = FILL_LIMIT + RUN_LIMIT + DRAIN_LIMIT + 100;
    localparam int          WATCHDOG_CYCLES = 10 + 300 + 2 * STREAM_CYCLES + 200;

    logic        BUS_CLK = 1'b0;
    logic        rst_n;
    rbcp_req_t   rbcp_req;
    logic        tcp_close_req;
    logic        tcp_rx_wr;
    logic [7:0]  tcp_rx_data;
    logic        tcp_tx_full;
    logic        rbcp_ack;
    logic [7:0]  rbcp_rd;
    logic        tcp_close_ack;
    logic [10:0] tcp_rx_wc;
    logic        tcp_tx_wr;
    logic [7:0]  tcp_tx_data;
    logic [7:0]  led;

    int          errors     = 0;
    int          stop_count = 0;     // Stops issued by the tests
    int          seen_stops = 0;     // Stops already applied to the model
    int          words_done = 0;     // Words fully received on TCP side
    int          lane       = 0;     // Next byte lane expected
    logic [31:0] next_word  = '0;    // Next count the source should write
    logic [31:0] exp_q[$];           // Words between source and TCP port
    logic        bp_random  = 1'b0;  // Random back-pressure
    logic        bp_hold    = 1'b0;  // Fixed level when not random

    eth_core #(
        .GPIO_BASEADDR (GPIO_BASEADDR_DEF),
        .GPIO_HIGHADDR (GPIO_HIGHADDR_DEF),
        .FIFO_DEPTH    (TB_FIFO_DEPTH)
    ) uut (
        .BUS_CLK       (BUS_CLK),
        .rst_n         (rst_n),
        .rbcp_req      (rbcp_req),
        .tcp_close_req (tcp_close_req),
        .tcp_rx_wr     (tcp_rx_wr),
        .tcp_rx_data   (tcp_rx_data),
        .tcp_tx_full   (tcp_tx_full),
        .rbcp_ack      (rbcp_ack),
        .rbcp_rd       (rbcp_rd),
        .tcp_close_ack (tcp_close_ack),
        .tcp_rx_wc     (tcp_rx_wc),
        .tcp_tx_wr     (tcp_tx_wr),
        .tcp_tx_data   (tcp_tx_data),
        .led           (led)
    );

    always #10 BUS_CLK = ~BUS_CLK;                      // 20 ns period

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected 8'h%02h, got 8'h%02h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input logic [10:0] exp, input logic [10:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %0b, got %0b", $time, name, exp, act);
        end
    endtask

    // One RBCP request, ack expected 2 edges after the edge that takes it
    task automatic rbcp_access(input logic write, input logic [31:0] addr,
                               input logic [7:0] wd, output logic [7:0] rd);
        int n;
        rd = 8'h00;
        @(posedge BUS_CLK);
        #2;
        rbcp_req.act  = 1'b1;
        rbcp_req.addr = addr;
        rbcp_req.wd   = wd;
        rbcp_req.we   = write;
        rbcp_req.re   = !write;
        @(posedge BUS_CLK);                             // Edge N
        #2;
        rbcp_req = '0;
        n = 0;
        do begin
            @(posedge BUS_CLK);
            #1;                                         // Registered outputs settled
            n++;
        end while (!rbcp_ack && n < 10);
        if (!rbcp_ack) begin
            errors++;
            $display("No rbcp_ack at %0t for access to address %08h", $time, addr);
        end else begin
            check_byte("rbcp_ack latency", 8'd2, 8'(n));
            rd = rbcp_rd;                               // Data valid with ack
        end
    endtask

    task automatic rbcp_write(input logic [31:0] addr, input logic [7:0] wd);
        logic [7:0] unused_rd;
        rbcp_access(1'b1, addr, wd, unused_rd);
    endtask

    task automatic rbcp_read(input logic [31:0] addr, output logic [7:0] rd);
        rbcp_access(1'b0, addr, 8'h00, rd);
    endtask

    task automatic reset_check();
        @(negedge BUS_CLK);
        check_bit("rbcp_ack", 1'b0, rbcp_ack);
        check_bit("tcp_tx_wr", 1'b0, tcp_tx_wr);
        check_word("tcp_rx_wc", 11'd0, tcp_rx_wc);
        check_byte("led", 8'hfb, led);                  // Only FIFO empty lit
    endtask

    task automatic register_test();
        logic [7:0] rd;
        rbcp_write(OUT_ADDR, 8'ha4);                    // Bit 0 clear, stream stays off
        rbcp_read(OUT_ADDR, rd);
        check_byte("rbcp_rd out reg", 8'ha4, rd);
        rbcp_read(IN_ADDR, rd);
        check_byte("rbcp_rd status", 8'h04, rd);        // Idle, FIFO empty
        rbcp_read(OUT_ADDR + 32'd5, rd);
        check_byte("rbcp_rd unmapped", 8'h00, rd);
        rbcp_read(FAR_ADDR, rd);
        check_byte("rbcp_rd far", 8'h00, rd);
        rbcp_write(FAR_ADDR, 8'h5b);                    // Must be dropped
        rbcp_read(OUT_ADDR, rd);
        check_byte("rbcp_rd after far write", 8'ha4, rd);
        rbcp_write(OUT_ADDR, 8'h00);
    endtask

    task automatic stream_check(input logic by_close);
        logic [7:0] rd;
        int         n;
        int         target;
        bp_random = 1'b0;
        bp_hold   = 1'b1;                               // Block TCP until FIFO fills
        rbcp_write(OUT_ADDR, 8'h00);
        rbcp_write(OUT_ADDR, 8'h01);                    // Rising start bit
        n = 0;
        while (exp_q.size() < TB_FIFO_DEPTH && n < FILL_LIMIT) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (exp_q.size() < TB_FIFO_DEPTH) begin
            errors++;
            $display("FIFO did not fill within %0d cycles at %0t", FILL_LIMIT, $time);
        end
        rbcp_read(IN_ADDR, rd);
        check_byte("rbcp_rd status full", 8'h03, rd);   // Running and full
        bp_random = 1'b1;
        target = words_done + STREAM_WORDS;
        n = 0;
        while (words_done < target && n < RUN_LIMIT) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (words_done < target) begin
            errors++;
            $display("Stream stalled at %0t after %0d words", $time, words_done);
        end
        if (by_close) begin
            @(posedge BUS_CLK);
            #2 tcp_close_req = 1'b1;
            @(posedge BUS_CLK);
            #2 tcp_close_req = 1'b0;
            @(negedge BUS_CLK);
            check_bit("tcp_close_ack", 1'b1, tcp_close_ack);
        end else begin
            rbcp_write(OUT_ADDR, 8'h00);
        end
        stop_count++;                                   // Model restarts at word 0
        n = 0;
        while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(negedge BUS_CLK);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("FIFO did not drain at %0t, %0d words left", $time, exp_q.size());
        end
        @(negedge BUS_CLK);
        check_bit("tcp_tx_wr after drain", 1'b0, tcp_tx_wr);
        bp_random = 1'b0;
        bp_hold   = 1'b0;
        rbcp_read(IN_ADDR, rd);
        check_byte("rbcp_rd status stopped", 8'h04, rd);
    endtask

    task automatic rx_count_test(input int k);
        @(posedge BUS_CLK);
        #2;
        tcp_rx_wr   = 1'b1;
        tcp_rx_data = 8'($urandom);
        for (int i = 1; i <= k; i++) begin
            @(posedge BUS_CLK);
            #2;
            if (i == k) tcp_rx_wr = 1'b0;              // Burst ends
            else tcp_rx_data = 8'($urandom);
            @(negedge BUS_CLK);
            check_word("tcp_rx_wc", 11'(i), tcp_rx_wc);
            if (i < k) check_bit("led[5]", 1'b0, led[5]);
        end
        @(negedge BUS_CLK);
        check_word("tcp_rx_wc after burst", 11'd0, tcp_rx_wc);
    endtask

    // Back-pressure driver
    initial begin
        tcp_tx_full = 1'b0;
        forever begin
            @(posedge BUS_CLK);
            #2 tcp_tx_full = bp_random ? 1'($urandom) : bp_hold;
        end
    end

    // Stream checker, rebuilds words LSB first and counts source writes
    initial begin
        forever begin
            @(negedge BUS_CLK);
            if (stop_count != seen_stops) begin
                next_word  = '0;
                seen_stops = stop_count;
            end
            if (rst_n && tcp_tx_wr) begin
                check_bit("tcp_tx_full", 1'b0, tcp_tx_full);
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Byte sent at %0t with no word pending", $time);
                end else begin
                    check_byte("tcp_tx_data", exp_q[0][8*lane +: 8], tcp_tx_data);
                    if (lane == 3) begin
                        void'(exp_q.pop_front());
                        words_done++;
                        lane = 0;
                    end else begin
                        lane++;
                    end
                end
            end
            if (rst_n && uut.fifo_write) begin
                exp_q.push_back(next_word);            // Lands at next edge
                next_word++;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge BUS_CLK);
        $display("Timeout after %0d cycles, %0d errors so far", WATCHDOG_CYCLES, errors);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        rbcp_req      = '0;
        tcp_close_req = 1'b0;
        tcp_rx_wr     = 1'b0;
        tcp_rx_data   = 8'h00;
        void'($urandom(32'h20cf));
        repeat (10) @(posedge BUS_CLK);
        #2 rst_n = 1'b1;
        reset_check();
        register_test();
        stream_check(1'b1);                             // Stop by close request
        stream_check(1'b0);                             // Restart, stop by start bit
        rx_count_test(5);
        rx_count_test(37);
        $display("Tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
